/* files.f */
uart_cfg_pkg.sv
uart_line_pkg.sv
uart_baud_gen.sv
uart_xmit.sv
uart_rcv.sv
uart_top.sv
tb_uart.sv

/* run_sim.sh */
#!/bin/sh
# build the uart testbench with verilator, run it and check the log.
rm -f build.log sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_uart \
  -f files.f -o sim_uart > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_uart > sim.log 2>&1 || true
cat sim.log
grep -q "SIMULATION PASSED" sim.log && exit 0 || exit 1

/* tb_uart.sv */
`timescale 1ns/1ps

module tb_uart;

  localparam int CLK_PERIOD_NS = 4;
  localparam int BIT_CLKS      = uart_cfg_pkg::TICKS_PER_BIT * uart_cfg_pkg::BAUD_DIV;
  localparam int FRAME_CLKS    = 12 * BIT_CLKS;
  localparam int NUM_FRAMES    = 26;
  localparam int TIMEOUT_NS    = NUM_FRAMES * FRAME_CLKS * CLK_PERIOD_NS + 4000;

  logic       sys_clk = 1'b0;
  logic       sys_rst_l;
  logic       xmit;
  logic [7:0] xmit_data;
  logic       xmit_done;
  logic       tx_line;
  logic       rx_line;
  logic [7:0] rcv_data;
  logic       rcv_rdy;
  logic       frame_err;

  logic       loop_sel;
  logic       drv_rx;
  integer     seed;
  logic       rx_seen;
  logic [8:0] held_rx;

  // bytes still owed by the transmitter, and {frame_err, data} owed by the receiver.
  logic [7:0] exp_tx_q[$];
  logic [8:0] exp_rx_q[$];

  uart_top dut_i (
    .sys_clk   (sys_clk),
    .sys_rst_l (sys_rst_l),
    .xmit      (xmit),
    .xmit_data (xmit_data),
    .xmit_done (xmit_done),
    .tx_line   (tx_line),
    .rx_line   (rx_line),
    .rcv_data  (rcv_data),
    .rcv_rdy   (rcv_rdy),
    .frame_err (frame_err)
  );

  always #(CLK_PERIOD_NS / 2) sys_clk = ~sys_clk;

  // loopback or a driven line.
  assign rx_line = loop_sel ? tx_line : drv_rx;

  task automatic abort_run();
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
    abort_run();
  endtask

  task automatic report_failure(input string what);
    $display("** Error: %s", what);
    abort_run();
  endtask

  task automatic wait_for_done();
    int cycles;
    cycles = 0;
    while (xmit_done !== 1'b1) begin
      @(negedge sys_clk);
      cycles++;
      if (cycles > 2 * FRAME_CLKS) begin
        report_failure("xmit_done did not rise within two frame times");
      end
    end
  endtask

  task automatic check_reset_values();
    int c;
    for (c = 0; c < 8; c++) begin
      @(negedge sys_clk);
      assert (tx_line === uart_line_pkg::LINE_IDLE)
        else report_mismatch("tx_line", 32'(tx_line), 32'(uart_line_pkg::LINE_IDLE));
      assert (rcv_rdy === 1'b0) else report_mismatch("rcv_rdy", 32'(rcv_rdy), 32'h0);
      assert (frame_err === 1'b0) else report_mismatch("frame_err", 32'(frame_err), 32'h0);
      if (c > 0) begin
        assert (xmit_done === 1'b1) else report_mismatch("xmit_done", 32'(xmit_done), 32'h1);
      end
    end
  endtask

  // one strobe cycle, expectations queued before the frame starts.
  task automatic strobe_byte(input logic [7:0] value);
    @(negedge sys_clk);
    exp_tx_q.push_back(value);
    exp_rx_q.push_back({1'b0, value});
    xmit      = 1'b1;
    xmit_data = value;
    @(negedge sys_clk);
    xmit = 1'b0;
    assert (xmit_done === 1'b0) else report_mismatch("xmit_done", 32'(xmit_done), 32'h0);
  endtask

  task automatic finish_frame();
    wait_for_done();
    assert (tx_line === uart_line_pkg::LINE_IDLE)
      else report_mismatch("tx_line", 32'(tx_line), 32'(uart_line_pkg::LINE_IDLE));
    assert (exp_tx_q.size() == 0) else report_failure("sent byte never appeared on tx_line");
    assert (exp_rx_q.size() == 0) else report_failure("sent byte produced no rcv_rdy pulse");
  endtask

  task automatic send_byte(input logic [7:0] value);
    wait_for_done();
    strobe_byte(value);
    finish_frame();
  endtask

  task automatic busy_strobe(input logic [7:0] first, input logic [7:0] second);
    wait_for_done();
    strobe_byte(first);
    repeat (5 * BIT_CLKS) @(negedge sys_clk);
    xmit      = 1'b1;
    xmit_data = second;
    @(negedge sys_clk);
    xmit = 1'b0;
    finish_frame();
    // quiet window. a stray frame would hit the monitor with an empty queue.
    repeat (FRAME_CLKS) @(negedge sys_clk);
    assert (xmit_done === 1'b1) else report_mismatch("xmit_done", 32'(xmit_done), 32'h1);
  endtask

  task automatic drive_frame(input logic [7:0] value, input logic stop_level);
    int i;
    exp_rx_q.push_back({stop_level == uart_line_pkg::LINE_START, value});
    @(negedge sys_clk);
    drv_rx = uart_line_pkg::LINE_START;
    repeat (BIT_CLKS) @(negedge sys_clk);
    for (i = 0; i < uart_cfg_pkg::WORD_LEN; i++) begin
      drv_rx = value[i];
      repeat (BIT_CLKS) @(negedge sys_clk);
    end
    drv_rx = stop_level;
    repeat (BIT_CLKS) @(negedge sys_clk);
    drv_rx = uart_line_pkg::LINE_IDLE;
    repeat (BIT_CLKS) @(negedge sys_clk);
    assert (exp_rx_q.size() == 0) else report_failure("driven frame produced no rcv_rdy pulse");
  endtask

  // samples each 64-clock cell at its middle.
  always begin : tx_monitor
    logic [7:0] exp_byte;
    int i;
    @(negedge tx_line);
    if (exp_tx_q.size() == 0) begin
      report_failure("tx_line started a frame with no byte pending");
    end
    exp_byte = exp_tx_q.pop_front();
    repeat (BIT_CLKS / 2) @(negedge sys_clk);
    assert (tx_line === uart_line_pkg::LINE_START)
      else report_mismatch("tx_line", 32'(tx_line), 32'(uart_line_pkg::LINE_START));
    for (i = 0; i < uart_cfg_pkg::WORD_LEN; i++) begin
      repeat (BIT_CLKS) @(negedge sys_clk);
      assert (tx_line === exp_byte[i])
        else report_mismatch("tx_line", 32'(tx_line), 32'(exp_byte[i]));
      assert (xmit_done === 1'b0) else report_mismatch("xmit_done", 32'(xmit_done), 32'h0);
    end
    repeat (BIT_CLKS) @(negedge sys_clk);
    assert (tx_line === uart_line_pkg::LINE_IDLE)
      else report_mismatch("tx_line", 32'(tx_line), 32'(uart_line_pkg::LINE_IDLE));
    assert (xmit_done === 1'b0) else report_mismatch("xmit_done", 32'(xmit_done), 32'h0);
  end

  always @(negedge sys_clk) begin : rx_checker
    logic [8:0] exp_rx;
    if (sys_rst_l === 1'b1) begin
      if (rcv_rdy === 1'b1) begin
        if (exp_rx_q.size() == 0) begin
          report_failure("rcv_rdy pulsed with no frame expected");
        end
        exp_rx = exp_rx_q.pop_front();
        assert (rcv_data === exp_rx[7:0])
          else report_mismatch("rcv_data", 32'(rcv_data), 32'(exp_rx[7:0]));
        assert (frame_err === exp_rx[8])
          else report_mismatch("frame_err", 32'(frame_err), 32'(exp_rx[8]));
        held_rx = exp_rx;
        rx_seen = 1'b1;
      end else if (rx_seen) begin
        // outputs hold between pulses.
        assert ({frame_err, rcv_data} === held_rx)
          else report_mismatch("{frame_err, rcv_data}", 32'({frame_err, rcv_data}),
                               32'(held_rx));
      end
    end
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    report_failure("watchdog expired before the test sequence finished");
  end

  initial begin : main_seq
    logic [31:0] rnd;
    int k;
    seed      = 32'h89953726;
    sys_rst_l = 1'b0;
    xmit      = 1'b0;
    xmit_data = 8'h00;
    drv_rx    = uart_line_pkg::LINE_IDLE;
    loop_sel  = 1'b0;
    rx_seen   = 1'b0;
    held_rx   = 9'h000;
    repeat (8) @(negedge sys_clk);
    sys_rst_l = 1'b1;
    check_reset_values();

    loop_sel = 1'b1;
    send_byte(8'hA5);
    send_byte(8'h3C);
    busy_strobe(8'h5A, 8'hC3);

    // bad stop bit, then a clean frame.
    loop_sel = 1'b0;
    drive_frame(8'h96, uart_line_pkg::LINE_START);
    drive_frame(8'h69, uart_line_pkg::LINE_IDLE);

    loop_sel = 1'b1;
    for (k = 0; k < 20; k++) begin
      rnd = $random(seed);
      send_byte(rnd[7:0]);
    end

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

/* uart_baud_gen.sv */
`timescale 1ns/1ps

module uart_baud_gen (
  input  logic sys_clk,
  input  logic sys_rst_l,
  output logic tick
);

  logic [uart_cfg_pkg::BAUD_CNT_W-1:0] div_cnt;

  // one tick per counter wrap.
  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      div_cnt <= '0;
      tick    <= 1'b0;
    end else begin
      tick <= (div_cnt == uart_cfg_pkg::BAUD_LAST);
      if (div_cnt == uart_cfg_pkg::BAUD_LAST) begin
        div_cnt <= '0;
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  tick_single_cycle: assert property (
    @(posedge sys_clk) disable iff (!sys_rst_l)
    tick |=> !tick
  );

endmodule

/* uart_cfg_pkg.sv */
package uart_cfg_pkg;

  // frame and rate.
  localparam int unsigned WORD_LEN      = 8;
  localparam int unsigned TICKS_PER_BIT = 16;
  localparam int unsigned BAUD_DIV      = 4;
  localparam int unsigned SAMPLE_TICK   = 7;

  // counter widths.
  localparam int unsigned BAUD_CNT_W = $clog2(BAUD_DIV);
  localparam int unsigned CELL_CNT_W = $clog2(TICKS_PER_BIT);
  localparam int unsigned BIT_CNT_W  = $clog2(WORD_LEN);

  // compare values sized to their counters.
  localparam logic [BAUD_CNT_W-1:0] BAUD_LAST   = BAUD_CNT_W'(BAUD_DIV - 1);
  localparam logic [CELL_CNT_W-1:0] CELL_LAST   = CELL_CNT_W'(TICKS_PER_BIT - 1);
  localparam logic [CELL_CNT_W-1:0] CELL_SHIFT  = CELL_CNT_W'(TICKS_PER_BIT - 2);
  localparam logic [CELL_CNT_W-1:0] CELL_SAMPLE = CELL_CNT_W'(SAMPLE_TICK);
  localparam logic [BIT_CNT_W-1:0]  BIT_LAST    = BIT_CNT_W'(WORD_LEN - 1);

endpackage

/* uart_line_pkg.sv */
package uart_line_pkg;

  // marking and spacing levels.
  localparam logic LINE_IDLE  = 1'b1;
  localparam logic LINE_START = 1'b0;

  // source of the transmit line.
  typedef enum logic [1:0] {
    SEL_START = 2'd0,
    SEL_STOP  = 2'd1,
    SEL_SHIFT = 2'd2
  } xmit_sel_t;

  // transmit fsm.
  typedef enum logic [2:0] {
    X_IDLE  = 3'd0,
    X_START = 3'd1,
    X_WAIT  = 3'd2,
    X_SHIFT = 3'd3,
    X_STOP  = 3'd4
  } xmit_state_t;

  // receive fsm.
  typedef enum logic [1:0] {
    R_IDLE  = 2'd0,
    R_START = 2'd1,
    R_DATA  = 2'd2,
    R_STOP  = 2'd3
  } rcv_state_t;

endpackage

/* uart_rcv.sv */
`timescale 1ns/1ps

module uart_rcv (
  input  logic                              sys_clk,
  input  logic                              sys_rst_l,
  input  logic                              tick,
  input  logic                              rx_line,
  output logic [uart_cfg_pkg::WORD_LEN-1:0] rcv_data,
  output logic                              rcv_rdy,
  output logic                              frame_err
);

  uart_line_pkg::rcv_state_t state;
  uart_line_pkg::rcv_state_t next_state;

  logic rx_meta;
  logic rx_sync;
  logic rx_prev;
  logic start_edge;
  logic sample;

  logic [uart_cfg_pkg::CELL_CNT_W-1:0] cell_cnt;
  logic [uart_cfg_pkg::BIT_CNT_W-1:0]  bit_cnt;
  logic [uart_cfg_pkg::WORD_LEN-1:0]   shift_reg;

  logic cell_clr;
  logic bit_clr;
  logic shift_ena;
  logic stop_ena;

  // two-flop synchronizer, then one more stage for the edge.
  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      rx_meta <= uart_line_pkg::LINE_IDLE;
      rx_sync <= uart_line_pkg::LINE_IDLE;
      rx_prev <= uart_line_pkg::LINE_IDLE;
    end else begin
      rx_meta <= rx_line;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  // a line held low after a bad stop bit is not a new start.
  assign start_edge = (rx_prev == uart_line_pkg::LINE_IDLE) &&
                      (rx_sync == uart_line_pkg::LINE_START);

  assign sample = tick && (cell_cnt == uart_cfg_pkg::CELL_SAMPLE);

  always_comb begin
    next_state = state;
    cell_clr   = 1'b0;
    bit_clr    = 1'b0;
    shift_ena  = 1'b0;
    stop_ena   = 1'b0;
    case (state)
      uart_line_pkg::R_IDLE: begin
        cell_clr = 1'b1;
        bit_clr  = 1'b1;
        if (start_edge) begin
          next_state = uart_line_pkg::R_START;
        end
      end
      // recheck mid start bit, a glitch returns to idle.
      uart_line_pkg::R_START: begin
        if (sample) begin
          if (rx_sync == uart_line_pkg::LINE_START) begin
            next_state = uart_line_pkg::R_DATA;
          end else begin
            next_state = uart_line_pkg::R_IDLE;
          end
        end
      end
      uart_line_pkg::R_DATA: begin
        if (sample) begin
          shift_ena = 1'b1;
          if (bit_cnt == uart_cfg_pkg::BIT_LAST) begin
            next_state = uart_line_pkg::R_STOP;
          end
        end
      end
      uart_line_pkg::R_STOP: begin
        if (sample) begin
          stop_ena   = 1'b1;
          next_state = uart_line_pkg::R_IDLE;
        end
      end
      default: next_state = uart_line_pkg::R_IDLE;
    endcase
  end

  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      state <= uart_line_pkg::R_IDLE;
    end else begin
      state <= next_state;
    end
  end

  // free running cell phase from the start edge.
  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      cell_cnt <= '0;
    end else if (cell_clr) begin
      cell_cnt <= '0;
    end else if (tick) begin
      cell_cnt <= cell_cnt + 1'b1;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      bit_cnt <= '0;
    end else if (bit_clr) begin
      bit_cnt <= '0;
    end else if (shift_ena) begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // lsb first, so new bits enter at the top.
  always_ff @(posedge sys_clk) begin
    if (shift_ena) begin
      shift_reg <= {rx_sync, shift_reg[uart_cfg_pkg::WORD_LEN-1:1]};
    end
  end

  always_ff @(posedge sys_clk) begin
    if (stop_ena) begin
      rcv_data <= shift_reg;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      rcv_rdy   <= 1'b0;
      frame_err <= 1'b0;
    end else begin
      rcv_rdy <= stop_ena;
      if (stop_ena) begin
        frame_err <= (rx_sync != uart_line_pkg::LINE_IDLE);
      end
    end
  end

  rdy_single_cycle: assert property (
    @(posedge sys_clk) disable iff (!sys_rst_l)
    rcv_rdy |=> !rcv_rdy
  );

endmodule

/* uart_top.sv */
`timescale 1ns/1ps

module uart_top (
  input  logic                              sys_clk,
  input  logic                              sys_rst_l,
  input  logic                              xmit,
  input  logic [uart_cfg_pkg::WORD_LEN-1:0] xmit_data,
  output logic                              xmit_done,
  output logic                              tx_line,
  input  logic                              rx_line,
  output logic [uart_cfg_pkg::WORD_LEN-1:0] rcv_data,
  output logic                              rcv_rdy,
  output logic                              frame_err
);

  // 16x bit rate enable, shared by both directions.
  logic tick;

  uart_baud_gen baud_gen_i (
    .sys_clk   (sys_clk),
    .sys_rst_l (sys_rst_l),
    .tick      (tick)
  );

  uart_xmit xmit_i (
    .sys_clk   (sys_clk),
    .sys_rst_l (sys_rst_l),
    .tick      (tick),
    .xmit      (xmit),
    .xmit_data (xmit_data),
    .tx_line   (tx_line),
    .xmit_done (xmit_done)
  );

  uart_rcv rcv_i (
    .sys_clk   (sys_clk),
    .sys_rst_l (sys_rst_l),
    .tick      (tick),
    .rx_line   (rx_line),
    .rcv_data  (rcv_data),
    .rcv_rdy   (rcv_rdy),
    .frame_err (frame_err)
  );

endmodule

/* uart_xmit.sv */
`timescale 1ns/1ps

module uart_xmit (
  input  logic                              sys_clk,
  input  logic                              sys_rst_l,
  input  logic                              tick,
  input  logic                              xmit,
  input  logic [uart_cfg_pkg::WORD_LEN-1:0] xmit_data,
  output logic                              tx_line,
  output logic                              xmit_done
);

  uart_line_pkg::xmit_state_t state;
  uart_line_pkg::xmit_state_t next_state;
  uart_line_pkg::xmit_sel_t   line_sel;

  logic [uart_cfg_pkg::CELL_CNT_W-1:0] cell_cnt;
  logic [uart_cfg_pkg::BIT_CNT_W-1:0]  bit_cnt;
  logic [uart_cfg_pkg::WORD_LEN-1:0]   shift_reg;

  logic load_shift;
  logic shift_ena;
  logic cell_clr;
  logic cell_inc;
  logic bit_clr;
  logic bit_inc;
  logic line_src;

  always_comb begin
    case (line_sel)
      uart_line_pkg::SEL_START: line_src = uart_line_pkg::LINE_START;
      uart_line_pkg::SEL_SHIFT: line_src = shift_reg[0];
      uart_line_pkg::SEL_STOP:  line_src = uart_line_pkg::LINE_IDLE;
      default:                  line_src = uart_line_pkg::LINE_IDLE;
    endcase
  end

  // all cell timing advances on tick only.
  always_comb begin
    next_state = state;
    line_sel   = uart_line_pkg::SEL_STOP;
    load_shift = 1'b0;
    shift_ena  = 1'b0;
    cell_clr   = 1'b0;
    cell_inc   = 1'b0;
    bit_clr    = 1'b0;
    bit_inc    = 1'b0;
    case (state)
      uart_line_pkg::X_IDLE: begin
        cell_clr = 1'b1;
        bit_clr  = 1'b1;
        if (xmit) begin
          load_shift = 1'b1;
          next_state = uart_line_pkg::X_START;
        end
      end
      uart_line_pkg::X_START: begin
        line_sel = uart_line_pkg::SEL_START;
        if (tick) begin
          if (cell_cnt == uart_cfg_pkg::CELL_LAST) begin
            cell_clr   = 1'b1;
            next_state = uart_line_pkg::X_WAIT;
          end else begin
            cell_inc = 1'b1;
          end
        end
      end
      // wait plus one shift tick makes a full data cell.
      uart_line_pkg::X_WAIT: begin
        line_sel = uart_line_pkg::SEL_SHIFT;
        if (tick) begin
          if (cell_cnt == uart_cfg_pkg::CELL_SHIFT) begin
            cell_clr   = 1'b1;
            next_state = uart_line_pkg::X_SHIFT;
          end else begin
            cell_inc = 1'b1;
          end
        end
      end
      uart_line_pkg::X_SHIFT: begin
        line_sel = uart_line_pkg::SEL_SHIFT;
        if (tick) begin
          shift_ena = 1'b1;
          bit_inc   = 1'b1;
          if (bit_cnt == uart_cfg_pkg::BIT_LAST) begin
            next_state = uart_line_pkg::X_STOP;
          end else begin
            next_state = uart_line_pkg::X_WAIT;
          end
        end
      end
      uart_line_pkg::X_STOP: begin
        line_sel = uart_line_pkg::SEL_STOP;
        if (tick) begin
          if (cell_cnt == uart_cfg_pkg::CELL_LAST) begin
            cell_clr   = 1'b1;
            next_state = uart_line_pkg::X_IDLE;
          end else begin
            cell_inc = 1'b1;
          end
        end
      end
      default: next_state = uart_line_pkg::X_IDLE;
    endcase
  end

  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      state     <= uart_line_pkg::X_IDLE;
      xmit_done <= 1'b0;
    end else begin
      state     <= next_state;
      xmit_done <= (state == uart_line_pkg::X_IDLE) && !xmit;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      cell_cnt <= '0;
    end else if (cell_clr) begin
      cell_cnt <= '0;
    end else if (cell_inc) begin
      cell_cnt <= cell_cnt + 1'b1;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      bit_cnt <= '0;
    end else if (bit_clr) begin
      bit_cnt <= '0;
    end else if (bit_inc) begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // lsb goes out first, ones shift in behind it.
  always_ff @(posedge sys_clk) begin
    if (load_shift) begin
      shift_reg <= xmit_data;
    end else if (shift_ena) begin
      shift_reg <= {1'b1, shift_reg[uart_cfg_pkg::WORD_LEN-1:1]};
    end
  end

  // line changes on tick edges, so every cell is exact.
  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      tx_line <= uart_line_pkg::LINE_IDLE;
    end else if (tick) begin
      tx_line <= line_src;
    end
  end

  idle_line_high: assert property (
    @(posedge sys_clk) disable iff (!sys_rst_l)
    (state == uart_line_pkg::X_IDLE) |-> (tx_line == uart_line_pkg::LINE_IDLE)
  );

  busy_not_done: assert property (
    @(posedge sys_clk) disable iff (!sys_rst_l)
    (state != uart_line_pkg::X_IDLE) |-> !xmit_done
  );

endmodule
